/* design/dmem_macros.svh */
`ifndef DMEM_MACROS_SVH
`define DMEM_MACROS_SVH

// byte address into the 8 KiB data memory
`define DMEM_ADDR_W 13

// 32-bit words behind that address space (8192 / 4)
`define DMEM_WORDS 2048

// width of one memory word and of the load/store data path
`define DMEM_DATA_W 32

`endif

/* design/dmem_pkg.sv */
package dmem_pkg;

   // access size as it comes from the core, encoded on two bits
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00, // lb / lbu / sb
      SIZE_HALF = 2'b01, // lh / lhu / sh
      SIZE_WORD = 2'b10  // lw / sw
   } mem_size_e;          // 2'b11 is not a legal size

   // one read word, seen either lane by lane or as two halfwords
   // byte 0 sits at the lowest address (little endian)
   typedef union packed {
      logic [3:0][7:0]  bytes;  // indexed by addr[1:0]
      logic [1:0][15:0] halves; // indexed by addr[1]
   } dmem_word_u;

endpackage

/* design/dmem_if.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// one memory access per cycle, no handshake
// a strobe that is high means the access happens in this cycle
interface dmem_if;

   logic                      we;    // write strobe
   logic                      re;    // read strobe
   logic [`DMEM_ADDR_W-3:0]   addr;  // word address
   logic [3:0]                be;    // byte lane enables
   logic [`DMEM_DATA_W-1:0]   wdata; // store data, already moved into its lanes
   logic [`DMEM_DATA_W-1:0]   rdata; // combinational read word

   // request stage drives the access
   modport request (output we, re, addr, be, wdata);

   // memory array, reads are not gated by re
   modport memory (input we, addr, be, wdata, output rdata);

   // load stage only watches the read side
   modport monitor (input re, rdata);

endinterface

/* design/data_mem.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// behavioral data memory, word organized with four byte lanes
// write is clocked, read is combinational off the word address
module data_mem (
   input logic    clk_i,
   dmem_if.memory mem
);

   // lane [0] holds the byte at the lowest address of the word
   logic [3:0][7:0] mem_q [`DMEM_WORDS];

   // byte enabled write
   // lanes whose enable is low keep their old contents
   always_ff @(posedge clk_i) begin
      if (mem.we) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (mem.be[lane]) begin
               mem_q[mem.addr][lane] <= mem.wdata[8*lane +: 8]; // lane data already shifted
            end
         end
      end
   end

   // read is asynchronous to the clock, so a load issued the cycle
   // after a store sees the new contents
   assign mem.rdata = mem_q[mem.addr]; // all four lanes, load stage picks

   // the request stage only strobes a write for a legal size,
   // so every write must touch at least one lane
   a_we_has_lanes : assert property (
      @(posedge clk_i) mem.we |-> (mem.be != 4'b0000)
   ) else $error("data_mem: write strobe with empty byte enable");

endmodule

/* design/lsu_request.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// request stage: alignment check, store lane steering, load forwarding
// everything towards the memory is combinational
module lsu_request (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    load_i,
   input  logic                    store_i,
   input  dmem_pkg::mem_size_e     size_i,
   input  logic [`DMEM_ADDR_W-1:0] addr_i,
   input  logic [`DMEM_DATA_W-1:0] wdata_i,
   dmem_if.request                 mem,
   output logic [1:0]              offset_o,
   output logic                    misalign_o
);

   logic       misalign_c; // address does not fit the size
   logic [3:0] be_c;
   logic [`DMEM_DATA_W-1:0] wdata_c;

   // lane enables and replicated store data per size
   // the replication puts the store data in every lane, be picks the right one
   always_comb begin
      misalign_c = 1'b0;
      be_c       = 4'b0000;
      wdata_c    = wdata_i;
      unique case (size_i)
         dmem_pkg::SIZE_BYTE: begin
            be_c    = 4'b0001 << addr_i[1:0]; // any offset is fine
            wdata_c = {4{wdata_i[7:0]}};
         end
         dmem_pkg::SIZE_HALF: begin
            misalign_c = addr_i[0];                   // must be on an even byte
            be_c       = 4'b0011 << {addr_i[1], 1'b0};
            wdata_c    = {2{wdata_i[15:0]}};
         end
         dmem_pkg::SIZE_WORD: begin
            misalign_c = |addr_i[1:0]; // must be on a word boundary
            be_c       = 4'b1111;
         end
         default: begin
            // unknown size is refused the same way as a bad address
            misalign_c = 1'b1;
         end
      endcase
   end

   // strobes only for accesses that pass the check
   assign mem.we    = store_i & ~misalign_c;
   assign mem.re    = load_i & ~misalign_c;
   assign mem.addr  = addr_i[`DMEM_ADDR_W-1:2];
   assign mem.be    = be_c;
   assign mem.wdata = wdata_c;

   assign offset_o = addr_i[1:0]; // lane select for the load stage

   // misalign is reported one cycle after the access, lined up with rdata_valid_o
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         misalign_o <= 1'b0;
      end else begin
         misalign_o <= (load_i | store_i) & misalign_c;
      end
   end

   // core must never ask for a load and a store in the same cycle
   a_no_load_and_store : assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(load_i && store_i)
   ) else $error("lsu_request: load and store requested together");

endmodule

/* design/load_extend.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// load stage with lane select, sign or zero extension and one register stage
module load_extend (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   dmem_if.monitor                 mem,
   input  logic [1:0]              offset_i,
   input  dmem_pkg::mem_size_e     size_i,
   input  logic                    unsigned_i,
   output logic [`DMEM_DATA_W-1:0] rdata_o,
   output logic                    rdata_valid_o
);

   dmem_pkg::dmem_word_u    word_u;
   logic [7:0]              byte_sel;
   logic [15:0]             half_sel;
   logic [`DMEM_DATA_W-1:0] ext_c;    // extended value before the register

   assign word_u   = mem.rdata;
   assign byte_sel = word_u.bytes[offset_i];     // byte lane by full offset
   assign half_sel = word_u.halves[offset_i[1]]; // upper or lower half

   // unsigned_i selects zero fill for byte and half loads
   always_comb begin
      unique case (size_i)
         dmem_pkg::SIZE_BYTE: begin
            if (unsigned_i) ext_c = {24'h000000, byte_sel};
            else            ext_c = {{24{byte_sel[7]}}, byte_sel};
         end
         dmem_pkg::SIZE_HALF: begin
            if (unsigned_i) ext_c = {16'h0000, half_sel};
            else            ext_c = {{16{half_sel[15]}}, half_sel};
         end
         default: begin
            ext_c = word_u; // the flag has no meaning for a word load
         end
      endcase
   end

   // the result register loads only on a read strobe
   // valid follows the strobe by exactly one cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_o       <= '0;
         rdata_valid_o <= 1'b0;
      end else begin
         rdata_valid_o <= mem.re;
         if (mem.re) begin
            rdata_o <= ext_c; // holds the last result between loads
         end
      end
   end

   // lane select relies on the read strobe coming only for aligned accesses
   a_read_aligned : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      mem.re |-> ((size_i != dmem_pkg::SIZE_HALF) || !offset_i[0]) &&
                 ((size_i != dmem_pkg::SIZE_WORD) || (offset_i == 2'b00))
   ) else $error("load_extend: read strobe for a misaligned access");

endmodule

/* design/dmem_top.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// data memory subsystem: request stage, memory, load stage
module dmem_top (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    load_i,
   input  logic                    store_i,
   input  logic [1:0]              size_i,     // 0 byte, 1 half, 2 word
   input  logic                    unsigned_i, // zero extend byte/half loads
   input  logic [`DMEM_ADDR_W-1:0] addr_i,     // byte address
   input  logic [`DMEM_DATA_W-1:0] wdata_i,
   output logic [`DMEM_DATA_W-1:0] rdata_o,
   output logic                    rdata_valid_o,
   output logic                    misalign_o
);

   dmem_pkg::mem_size_e size_e; // raw port bits seen as the size enum
   logic [1:0]          offset;  // byte offset, request stage to load stage

   assign size_e = dmem_pkg::mem_size_e'(size_i);

   dmem_if u_mem_if ();

   lsu_request u_lsu_request (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .load_i     (load_i),
      .store_i    (store_i),
      .size_i     (size_e),
      .addr_i     (addr_i),
      .wdata_i    (wdata_i),
      .mem        (u_mem_if.request),
      .offset_o   (offset),
      .misalign_o (misalign_o)
   );

   // no reset on the array
   data_mem u_data_mem (
      .clk_i (clk_i),
      .mem   (u_mem_if.memory)
   );

   load_extend u_load_extend (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .mem           (u_mem_if.monitor),
      .offset_i      (offset),
      .size_i        (size_e),
      .unsigned_i    (unsigned_i),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

endmodule

/* sim/dmem_tb.sv */
`timescale 1ns/10ps
`include "dmem_macros.svh"

// self-checking testbench for dmem_top
// directed table first, then an LCG driven back-to-back run against a byte model
module dmem_tb;

   localparam int CLK_PERIOD = 4;  // ns
   localparam int DRIVE_DLY  = 1;  // inputs change this long after the rising edge
   localparam int TBL_MAX    = 32; // room in the stimulus table
   localparam int N_FILL     = 32; // words preset before the random run
   localparam int N_RAND     = 200;
   localparam int RAND_BASE  = 13'h0400; // byte address of the random region

   localparam logic [1:0] OP_IDLE  = 2'd0;
   localparam logic [1:0] OP_LOAD  = 2'd1;
   localparam logic [1:0] OP_STORE = 2'd2;

   localparam logic [1:0] SZ_B = 2'd0;
   localparam logic [1:0] SZ_H = 2'd1;
   localparam logic [1:0] SZ_W = 2'd2;

   logic                    clk_i;
   logic                    rst_n_i;
   logic                    load_i;
   logic                    store_i;
   logic [1:0]              size_i;
   logic                    unsigned_i;
   logic [`DMEM_ADDR_W-1:0] addr_i;
   logic [`DMEM_DATA_W-1:0] wdata_i;
   logic [`DMEM_DATA_W-1:0] rdata_o;
   logic                    rdata_valid_o;
   logic                    misalign_o;

   // stimulus table with one access per row
   logic [1:0]              tbl_op    [TBL_MAX];
   logic [1:0]              tbl_size  [TBL_MAX];
   logic                    tbl_uns   [TBL_MAX];
   logic [`DMEM_ADDR_W-1:0] tbl_addr  [TBL_MAX];
   logic [`DMEM_DATA_W-1:0] tbl_wdata [TBL_MAX];
   logic [`DMEM_DATA_W-1:0] tbl_exp   [TBL_MAX]; // only meaningful for loads
   logic                    tbl_mis   [TBL_MAX];
   int                      n_rows;

   logic [7:0] model_mem [1 << `DMEM_ADDR_W]; // byte image of what the DUT should hold

   // what the outputs must show one cycle after the last issued access
   logic                    exp_valid;
   logic [`DMEM_DATA_W-1:0] exp_data;
   logic                    exp_mis;

   logic [31:0] lcg_state;
   int          errors;
   int          test_errs;
   int          tests_run;
   int          tests_failed;

   dmem_top u_dmem_top (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .load_i        (load_i),
      .store_i       (store_i),
      .size_i        (size_i),
      .unsigned_i    (unsigned_i),
      .addr_i        (addr_i),
      .wdata_i       (wdata_i),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o),
      .misalign_o    (misalign_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // every access gets at most four clock periods, plus reset and slack
   initial begin
      #((TBL_MAX + N_FILL + N_RAND) * 4 * CLK_PERIOD + 200);
      $display("timeout: simulation did not finish in the expected time");
      $display("TEST FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // numerical recipes constants
      return lcg_state;
   endfunction

   task automatic add_row(input logic [1:0] op, input logic [1:0] size, input logic uns,
                          input logic [`DMEM_ADDR_W-1:0] addr,
                          input logic [`DMEM_DATA_W-1:0] wdata,
                          input logic [`DMEM_DATA_W-1:0] exp, input logic mis);
      tbl_op[n_rows]    = op;
      tbl_size[n_rows]  = size;
      tbl_uns[n_rows]   = uns;
      tbl_addr[n_rows]  = addr;
      tbl_wdata[n_rows] = wdata;
      tbl_exp[n_rows]   = exp;
      tbl_mis[n_rows]   = mis;
      n_rows++;
   endtask

   // little endian byte model with the lowest address in bits 7:0
   task automatic model_store(input logic [1:0] size, input int addr,
                              input logic [`DMEM_DATA_W-1:0] data);
      model_mem[addr] = data[7:0];
      if (size != SZ_B) model_mem[addr + 1] = data[15:8];
      if (size == SZ_W) begin
         model_mem[addr + 2] = data[23:16];
         model_mem[addr + 3] = data[31:24];
      end
   endtask

   function automatic logic [31:0] model_load(input logic [1:0] size, input logic uns,
                                              input int addr);
      logic [7:0]  b;
      logic [15:0] h;
      b = model_mem[addr];
      h = {model_mem[addr + 1], model_mem[addr]};
      case (size)
         SZ_B:    return uns ? {24'h000000, b} : {{24{b[7]}}, b};
         SZ_H:    return uns ? {16'h0000, h} : {{16{h[15]}}, h};
         default: return {model_mem[addr + 3], model_mem[addr + 2], h};
      endcase
   endfunction

   task automatic note_error();
      errors++;
      test_errs++;
   endtask

   // outputs are registered, so right after the edge they are stable
   task automatic check_outputs();
      if (rdata_valid_o !== exp_valid) begin
         $display("Error at %0t: rdata_valid_o got %b expected %b",
                  $time, rdata_valid_o, exp_valid);
         note_error();
      end
      if (exp_valid && (rdata_o !== exp_data)) begin
         $display("Error at %0t: rdata_o got %h expected %h", $time, rdata_o, exp_data);
         note_error();
      end
      if (misalign_o !== exp_mis) begin
         $display("Error at %0t: misalign_o got %b expected %b", $time, misalign_o, exp_mis);
         note_error();
      end
   endtask

   // check the previous access one cycle on, then present the next one
   task automatic issue(input logic [1:0] op, input logic [1:0] size, input logic uns,
                        input logic [`DMEM_ADDR_W-1:0] addr,
                        input logic [`DMEM_DATA_W-1:0] wdata,
                        input logic [`DMEM_DATA_W-1:0] exp, input logic mis);
      @(posedge clk_i);
      #DRIVE_DLY;
      check_outputs();
      load_i     = (op == OP_LOAD);
      store_i    = (op == OP_STORE);
      size_i     = size;
      unsigned_i = uns;
      addr_i     = addr;
      wdata_i    = wdata;
      exp_valid  = (op == OP_LOAD) && !mis; // misaligned load gives no result
      exp_data   = exp;
      exp_mis    = (op != OP_IDLE) && mis;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errs != 0) tests_failed++;
      $display("[%s] %s (%0d errors)", (test_errs == 0) ? "pass" : "fail", name, test_errs);
      test_errs = 0;
   endtask

   initial begin
      logic [31:0]             r;
      logic [1:0]              op;
      logic [1:0]              sz;
      logic [`DMEM_ADDR_W-1:0] a;
      logic [`DMEM_DATA_W-1:0] d;
      logic [`DMEM_DATA_W-1:0] e;

      rst_n_i    = 1'b0;
      load_i     = 1'b0;
      store_i    = 1'b0;
      size_i     = SZ_W;
      unsigned_i = 1'b0;
      addr_i     = '0;
      wdata_i    = '0;
      exp_valid  = 1'b0;
      exp_data   = '0;
      exp_mis    = 1'b0;
      lcg_state  = 32'ha05111a2;
      errors     = 0;
      test_errs  = 0;
      tests_run  = 0;
      tests_failed = 0;
      n_rows     = 0;

      // word store and readback
      add_row(OP_STORE, SZ_W, 0, 13'h0010, 32'h11223344, 32'h0, 0);
      add_row(OP_LOAD,  SZ_W, 0, 13'h0010, 32'h0, 32'h11223344, 0);
      // byte and half stores into single lanes
      add_row(OP_STORE, SZ_B, 0, 13'h0011, 32'h000000aa, 32'h0, 0);
      add_row(OP_STORE, SZ_B, 0, 13'h0013, 32'h000000bb, 32'h0, 0);
      add_row(OP_LOAD,  SZ_W, 0, 13'h0010, 32'h0, 32'hbb22aa44, 0);
      add_row(OP_STORE, SZ_H, 0, 13'h0012, 32'h0000ccdd, 32'h0, 0);
      add_row(OP_STORE, SZ_H, 0, 13'h0010, 32'h00008001, 32'h0, 0);
      add_row(OP_LOAD,  SZ_W, 0, 13'h0010, 32'h0, 32'hccdd8001, 0);
      // sign and zero extension of the bytes 85 7f f0 80 from low to high
      add_row(OP_STORE, SZ_W, 0, 13'h0020, 32'h80f07f85, 32'h0, 0);
      add_row(OP_LOAD,  SZ_B, 0, 13'h0020, 32'h0, 32'hffffff85, 0);
      add_row(OP_LOAD,  SZ_B, 1, 13'h0020, 32'h0, 32'h00000085, 0);
      add_row(OP_LOAD,  SZ_B, 0, 13'h0021, 32'h0, 32'h0000007f, 0);
      add_row(OP_LOAD,  SZ_B, 0, 13'h0022, 32'h0, 32'hfffffff0, 0);
      add_row(OP_LOAD,  SZ_B, 1, 13'h0023, 32'h0, 32'h00000080, 0);
      add_row(OP_LOAD,  SZ_H, 0, 13'h0020, 32'h0, 32'h00007f85, 0);
      add_row(OP_LOAD,  SZ_H, 0, 13'h0022, 32'h0, 32'hffff80f0, 0);
      add_row(OP_LOAD,  SZ_H, 1, 13'h0022, 32'h0, 32'h000080f0, 0);
      // misaligned accesses are refused and leave the word alone
      add_row(OP_STORE, SZ_H, 0, 13'h0021, 32'h0000ffff, 32'h0, 1);
      add_row(OP_STORE, SZ_W, 0, 13'h0022, 32'h00000000, 32'h0, 1);
      add_row(OP_LOAD,  SZ_W, 0, 13'h0023, 32'h0, 32'h0, 1);
      add_row(OP_LOAD,  SZ_H, 0, 13'h0023, 32'h0, 32'h0, 1);
      add_row(OP_LOAD,  SZ_W, 0, 13'h0020, 32'h0, 32'h80f07f85, 0);
      // only the low byte of the store data lands in lane 3
      add_row(OP_STORE, SZ_B, 0, 13'h0033, 32'h12345696, 32'h0, 0);
      add_row(OP_LOAD,  SZ_B, 0, 13'h0033, 32'h0, 32'hffffff96, 0);

      repeat (4) @(posedge clk_i);
      #DRIVE_DLY;
      rst_n_i = 1'b1;
      if (rdata_valid_o !== 1'b0) begin
         $display("Error at %0t: rdata_valid_o got %b expected 0", $time, rdata_valid_o);
         note_error();
      end
      if (misalign_o !== 1'b0) begin
         $display("Error at %0t: misalign_o got %b expected 0", $time, misalign_o);
         note_error();
      end
      if (rdata_o !== '0) begin
         $display("Error at %0t: rdata_o got %h expected %h", $time, rdata_o, 32'h0);
         note_error();
      end
      finish_test("reset values");

      for (int i = 0; i < n_rows; i++) begin
         issue(tbl_op[i], tbl_size[i], tbl_uns[i], tbl_addr[i], tbl_wdata[i],
               tbl_exp[i], tbl_mis[i]);
         if ((tbl_op[i] == OP_STORE) && !tbl_mis[i]) begin
            model_store(tbl_size[i], tbl_addr[i], tbl_wdata[i]);
         end
         issue(OP_IDLE, SZ_W, 0, '0, '0, '0, 0); // result of row i checked here
         finish_test($sformatf("table row %0d", i));
      end

      // preset the random region so every random load reads known bytes
      for (int i = 0; i < N_FILL; i++) begin
         a = RAND_BASE + 4 * i;
         d = next_rand();
         issue(OP_STORE, SZ_W, 0, a, d, '0, 0);
         model_store(SZ_W, a, d);
      end
      issue(OP_IDLE, SZ_W, 0, '0, '0, '0, 0);
      finish_test("random region fill");

      // back to back aligned traffic with one access per cycle
      for (int i = 0; i < N_RAND; i++) begin
         r  = next_rand();
         op = r[0] ? OP_LOAD : OP_STORE;
         sz = r[2:1] % 3;                                 // byte, half or word
         a  = RAND_BASE + 4 * r[8:4];                      // one of the preset words
         if (sz == SZ_B) a = a + r[10:9];
         if (sz == SZ_H) a = a + {r[10], 1'b0};
         d  = next_rand();
         e  = model_load(sz, r[3], a);
         issue(op, sz, r[3], a, d, e, 0);
         if (op == OP_STORE) model_store(sz, a, d);
      end
      issue(OP_IDLE, SZ_W, 0, '0, '0, '0, 0);
      issue(OP_IDLE, SZ_W, 0, '0, '0, '0, 0); // checks that valid drops after the last load
      finish_test("random back-to-back run");

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+design
design/dmem_pkg.sv
design/dmem_if.sv
design/data_mem.sv
design/lsu_request.sv
design/load_extend.sv
design/dmem_top.sv
sim/dmem_tb.sv
